/* rtl/msx_defs.svh */
`ifndef MSX_DEFS_SVH
`define MSX_DEFS_SVH

// SDRAM byte address width, 128 MB reach
`define MSX_RAM_ADDR_W 27

// Requests the SDRAM may hold at once
`define MSX_CREDITS 4

// RAM mapper reach in 16 KB segments, as log2
`define MSX_RAM_SEGS_LOG2 8

`endif

/* rtl/msx_slot_pkg.sv */
package msx_slot_pkg;

    // Cartridge mapper kinds handled by the ROM mapper
    typedef enum logic [1:0] {
        MAP_PLAIN  = 2'd0,      // No banking, page maps straight through
        MAP_ASCII8 = 2'd1       // Four 8 KB banks at 4000h..BFFFh
    } mapper_typ_t;

    // ROM page decode, base counted in 8 KB units
    typedef struct packed {
        logic        is_ram;    // Always top bit
        mapper_typ_t mapper;
        logic [12:0] base_bank;
    } rom_view_t;

    // RAM page decode, base counted in 16 KB units
    typedef struct packed {
        logic        is_ram;    // Shared with rom_view
        logic        ro;        // Writes dropped when set
        logic [13:0] base_seg;
    } ram_view_t;

    // One 16 KB page descriptor
    // is_ram picks which of the two views is meaningful
    typedef union packed {
        rom_view_t rom_view;
        ram_view_t ram_view;
    } page_cfg_u;

endpackage

/* rtl/msx_mem_pkg.sv */
package msx_mem_pkg;

    // SDRAM request direction
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

    // What a CPU page resolves to
    typedef enum logic {
        REG_ROM = 1'b0,         // Cartridge image, read only
        REG_RAM = 1'b1          // Mapped RAM
    } region_t;

endpackage

/* rtl/rom_mapper.sv */
`timescale 1ns/1ns

module rom_mapper
    import msx_slot_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req,        // Memory access strobe
    input  logic        cpu_wr,
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_dout,       // Bank number on a select write
    input  page_cfg_u   page,           // Descriptor of the addressed page
    output logic [19:0] rom_offset,     // Offset into the cartridge image
    output logic        rom_bank_wr     // Write consumed as a bank select
);
    logic [7:0] bank [4];               // ASCII8 bank registers
    logic [1:0] win;                    // 8 KB window index
    logic [7:0] bank_sel;               // Bank of the addressed window
    logic [1:0] page_rel;               // Page position counted from page 1
    logic       is_ascii8;

    assign is_ascii8 = !page.rom_view.is_ram && (page.rom_view.mapper == MAP_ASCII8);

    // Windows 4000h, 6000h, 8000h, A000h map to 0..3
    // Bit 15 splits the low pair from the high pair and bit 13 picks within a pair
    assign win      = {cpu_addr[15], cpu_addr[13]};
    assign bank_sel = bank[win];

    assign page_rel = cpu_addr[15:14] - 2'd1;   // Page 0 wraps to the top

    // Select registers live at 6000h..7FFFh with one per 2 KB
    assign rom_bank_wr = cpu_req && cpu_wr && is_ascii8 && (cpu_addr[15:13] == 3'b011);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= 8'(i);               // Linear layout out of reset
            end
        end else if (rom_bank_wr) begin
            bank[cpu_addr[12:11]] <= cpu_dout;  // Visible from next cycle
        end
    end

    always_comb begin
        case (page.rom_view.mapper)
            MAP_ASCII8: begin
                // Bank times 8 KB wrapping at the 1 MB image limit
                rom_offset = 20'({bank_sel, cpu_addr[12:0]});
            end
            default: begin
                rom_offset = {4'd0, page_rel, cpu_addr[13:0]};  // Plain image
            end
        endcase
    end

    // Each bank register moves only on a select write aimed at it
    for (genvar g = 0; g < 4; g++) begin : g_bank_chk
        a_bank_hold: assert property (
            @(posedge clk) disable iff (rst)
            !(rom_bank_wr && (cpu_addr[12:11] == 2'(g))) |=> (bank[g] == $past(bank[g]))
        );
    end

endmodule

/* rtl/ram_mapper.sv */
`timescale 1ns/1ns
`include "msx_defs.svh"

module ram_mapper (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_io_wr,      // I/O write strobe
    input  logic [15:0] cpu_addr,       // Low byte is the port number
    input  logic [7:0]  cpu_dout,       // Segment number on a port write
    output logic [21:0] ram_offset      // Segment base plus page offset
);
    // Segment bits the RAM behind the mapper can decode
    localparam logic [7:0] SEG_MASK = 8'((1 << `MSX_RAM_SEGS_LOG2) - 1);

    logic [7:0] seg [4];                // Segment register per CPU page
    logic [7:0] seg_sel;
    logic       port_hit;

    // Ports FCh..FFh with the low two bits picking the page
    assign port_hit = cpu_io_wr && (cpu_addr[7:2] == 6'b111111);

    always_ff @(posedge clk) begin
        if (rst) begin
            // MSX BIOS default puts page 0 on segment 3 down to page 3 on 0
            for (int i = 0; i < 4; i++) begin
                seg[i] <= 8'(3 - i);
            end
        end else if (port_hit) begin
            seg[cpu_addr[1:0]] <= cpu_dout & SEG_MASK;  // Upper bits ignored
        end
    end

    assign seg_sel    = seg[cpu_addr[15:14]];
    assign ram_offset = {seg_sel, cpu_addr[13:0]};      // Segment times 16 KB

    // A segment register moves only on a write to its own port
    for (genvar g = 0; g < 4; g++) begin : g_seg_chk
        a_seg_hold: assert property (
            @(posedge clk) disable iff (rst)
            !(port_hit && (cpu_addr[1:0] == 2'(g))) |=> (seg[g] == $past(seg[g]))
        );
    end

endmodule

/* rtl/slot_mem_arbiter.sv */
`timescale 1ns/1ns
`include "msx_defs.svh"

module slot_mem_arbiter
    import msx_slot_pkg::*;
    import msx_mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_req,
    input  logic                       cpu_wr,
    input  logic [15:0]                cpu_addr,
    input  logic [7:0]                 cpu_dout,
    input  page_cfg_u                  page_cfg [4],
    input  logic [19:0]                rom_offset,     // From ROM mapper
    input  logic [21:0]                ram_offset,     // From RAM mapper
    input  logic                       rom_bank_wr,    // Write already consumed
    output logic                       cpu_ready,      // A credit is free
    output logic [7:0]                 cpu_din,
    output logic                       cpu_din_valid,
    output logic                       ram_req,
    output logic [`MSX_RAM_ADDR_W-1:0] ram_addr,
    output logic [7:0]                 ram_din,
    output mem_op_t                    ram_op,
    input  logic                       ram_credit,     // One per finished request
    input  logic [7:0]                 ram_dout,
    input  logic                       ram_dout_valid  // Comes with a read credit
);
    localparam int ADDR_W = `MSX_RAM_ADDR_W;
    localparam int CRED_W = $clog2(`MSX_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`MSX_CREDITS);

    page_cfg_u         pg;              // Descriptor of the addressed page
    region_t           region;
    logic [ADDR_W-1:0] rom_addr;
    logic [ADDR_W-1:0] ram_addr_c;
    logic [ADDR_W-1:0] addr_next;
    logic              blocked;         // Access never reaches SDRAM
    logic              issue;
    logic [CRED_W-1:0] credits;         // Requests SDRAM can still take

    assign pg     = page_cfg[cpu_addr[15:14]];
    assign region = pg.rom_view.is_ram ? REG_RAM : REG_ROM;

    // Page base in 8 KB units for ROM, 16 KB units for RAM
    assign rom_addr   = ADDR_W'({pg.rom_view.base_bank, 13'd0}) + ADDR_W'(rom_offset);
    assign ram_addr_c = ADDR_W'({pg.ram_view.base_seg, 14'd0}) + ADDR_W'(ram_offset);
    assign addr_next  = (region == REG_RAM) ? ram_addr_c : rom_addr;

    // Bank selects, ROM writes and read-only RAM writes are swallowed here
    always_comb begin
        blocked = rom_bank_wr;
        if (cpu_wr && (region == REG_ROM)) begin
            blocked = 1'b1;
        end
        if (cpu_wr && (region == REG_RAM) && pg.ram_view.ro) begin
            blocked = 1'b1;
        end
    end

    // The registered request still holds a credit until it is sent
    assign cpu_ready = credits > CRED_W'(ram_req);
    assign issue     = cpu_req && cpu_ready && !blocked;

    always_ff @(posedge clk) begin
        if (rst) begin
            ram_req       <= 1'b0;
            credits       <= CRED_MAX;
            cpu_din_valid <= 1'b0;
        end else begin
            ram_req       <= issue;                     // One cycle after cpu_req
            credits       <= credits - CRED_W'(ram_req) + CRED_W'(ram_credit);
            cpu_din_valid <= ram_dout_valid;            // Reads only
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ram_addr <= addr_next;
            ram_din  <= cpu_dout;
            ram_op   <= cpu_wr ? MEM_WRITE : MEM_READ;
        end
        if (ram_dout_valid) begin
            cpu_din <= ram_dout;                        // In order, no tagging
        end
    end

    // SDRAM must not hand back more credits than were spent
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credits <= CRED_MAX
    );

    // A request goes out only against a held credit
    a_req_has_credit: assert property (
        @(posedge clk) disable iff (rst)
        ram_req |-> (credits != '0)
    );

endmodule

/* rtl/msx_slots.sv */
`timescale 1ns/1ns
`include "msx_defs.svh"

module msx_slots
    import msx_slot_pkg::*;
    import msx_mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_req,        // Memory access pulse
    input  logic                       cpu_wr,
    input  logic [15:0]                cpu_addr,
    input  logic [7:0]                 cpu_dout,       // Data from CPU
    input  logic                       cpu_io_wr,      // I/O write pulse
    input  page_cfg_u                  page_cfg [4],   // Static page layout
    output logic                       cpu_ready,
    output logic [7:0]                 cpu_din,        // Read data to CPU
    output logic                       cpu_din_valid,
    output logic                       ram_req,
    output logic [`MSX_RAM_ADDR_W-1:0] ram_addr,
    output logic [7:0]                 ram_din,
    output mem_op_t                    ram_op,
    input  logic                       ram_credit,
    input  logic [7:0]                 ram_dout,
    input  logic                       ram_dout_valid
);
    logic [19:0] rom_offset;
    logic [21:0] ram_offset;
    logic        rom_bank_wr;

    // Cartridge banking, sees only the addressed page's descriptor
    rom_mapper u_rom_mapper (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_addr    (cpu_addr),
        .cpu_dout    (cpu_dout),
        .page        (page_cfg[cpu_addr[15:14]]),
        .rom_offset  (rom_offset),
        .rom_bank_wr (rom_bank_wr)
    );

    // Memory mapper segments, loaded over I/O ports FCh..FFh
    ram_mapper u_ram_mapper (
        .clk        (clk),
        .rst        (rst),
        .cpu_io_wr  (cpu_io_wr),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .ram_offset (ram_offset)
    );

    slot_mem_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .cpu_req        (cpu_req),
        .cpu_wr         (cpu_wr),
        .cpu_addr       (cpu_addr),
        .cpu_dout       (cpu_dout),
        .page_cfg       (page_cfg),
        .rom_offset     (rom_offset),
        .ram_offset     (ram_offset),
        .rom_bank_wr    (rom_bank_wr),
        .cpu_ready      (cpu_ready),
        .cpu_din        (cpu_din),
        .cpu_din_valid  (cpu_din_valid),
        .ram_req        (ram_req),
        .ram_addr       (ram_addr),
        .ram_din        (ram_din),
        .ram_op         (ram_op),
        .ram_credit     (ram_credit),
        .ram_dout       (ram_dout),
        .ram_dout_valid (ram_dout_valid)
    );

endmodule

/* testbench/sdram_model.sv */
`timescale 1ns/1ns
`include "msx_defs.svh"

module sdram_model
    import msx_mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hold,           // Withholds completions and credits
    input  logic                       ram_req,
    input  logic [`MSX_RAM_ADDR_W-1:0] ram_addr,
    input  logic [7:0]                 ram_din,
    input  mem_op_t                    ram_op,
    output logic                       ram_credit,     // One per finished request
    output logic [7:0]                 ram_dout,
    output logic                       ram_dout_valid
);
    localparam int ADDR_W = `MSX_RAM_ADDR_W;

    logic [7:0]        mem [logic [ADDR_W-1:0]];   // Sparse, only written bytes
    logic [ADDR_W+8:0] pend [$];                   // {op, addr, data}, oldest first
    logic [ADDR_W+8:0] head;
    logic [31:0]       lfsr;
    logic              busy;                       // Head request is timing out
    int                wait_cnt;

    // Unwritten bytes read back as a mix of every address byte
    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'(a[ADDR_W-1:24]) ^ 8'h5a;
    endfunction

    // Three LFSR bits per pick, folded onto 1..6 cycles
    function automatic int latency();
        logic [2:0] v;
        v = 3'd0;
        for (int i = 0; i < 3; i++) begin
            v    = {v[1:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return 1 + int'(v) % 6;
    endfunction

    initial begin
        ram_credit     = 1'b0;
        ram_dout       = 8'd0;
        ram_dout_valid = 1'b0;
    end

    always @(posedge clk) begin
        ram_credit     <= 1'b0;
        ram_dout_valid <= 1'b0;
        if (rst) begin
            pend.delete();
            busy     = 1'b0;
            wait_cnt = 0;
            lfsr     = 32'hd24e;
        end else begin
            if (ram_req) begin
                pend.push_back({ram_op, ram_addr, ram_din});
            end
            if (busy) begin
                if (wait_cnt > 1) begin
                    wait_cnt--;
                end else if (!hold) begin
                    head = pend.pop_front();
                    if (head[ADDR_W+8]) begin
                        mem[head[ADDR_W+7:8]] = head[7:0];
                    end else begin
                        ram_dout       <= mem.exists(head[ADDR_W+7:8]) ?
                                          mem[head[ADDR_W+7:8]] : fill_byte(head[ADDR_W+7:8]);
                        ram_dout_valid <= 1'b1;     // Read data rides with the credit
                    end
                    ram_credit <= 1'b1;
                    busy = 1'b0;
                end
            end
            if (!busy && pend.size() != 0) begin
                busy     = 1'b1;                    // Next request in order
                wait_cnt = latency();
            end
        end
    end

endmodule

/* testbench/tb_msx_slots.sv */
`timescale 1ns/1ns
`include "msx_defs.svh"

module tb_msx_slots
    import msx_slot_pkg::*;
    import msx_mem_pkg::*;
();
    localparam int ADDR_W  = `MSX_RAM_ADDR_W;
    localparam int TIMEOUT = 500;                       // Cycles allowed per wait
    localparam logic [7:0] SEG_MASK = 8'((1 << `MSX_RAM_SEGS_LOG2) - 1);

    logic              clk;
    logic              rst;
    logic              cpu_req;
    logic              cpu_wr;
    logic [15:0]       cpu_addr;
    logic [7:0]        cpu_dout;
    logic              cpu_io_wr;
    page_cfg_u         page_cfg [4];
    logic              cpu_ready;
    logic [7:0]        cpu_din;
    logic              cpu_din_valid;
    logic              ram_req;
    logic [ADDR_W-1:0] ram_addr;
    logic [7:0]        ram_din;
    mem_op_t           ram_op;
    logic              ram_credit;
    logic [7:0]        ram_dout;
    logic              ram_dout_valid;
    logic              hold;                            // Back-pressure on the SDRAM

    logic [7:0]        mdl_bank [4];                    // Expected ASCII8 banks
    logic [7:0]        mdl_seg [4];                     // Expected mapper segments
    logic [7:0]        shadow [logic [ADDR_W-1:0]];     // Bytes written so far
    logic [ADDR_W+8:0] exp_req [$];                     // {op, addr, data}
    logic [7:0]        exp_rd [$];
    logic [31:0]       lfsr;
    string             cur_test;
    int                run_errs;
    int                cmp_errs;
    int                run_checks;
    int                cmp_checks;
    int                errs_at_start;
    int                tests_pass;
    int                tests_fail;

    msx_slots dut (.*);

    sdram_model sdram (
        .clk(clk), .rst(rst), .hold(hold),
        .ram_req(ram_req), .ram_addr(ram_addr), .ram_din(ram_din), .ram_op(ram_op),
        .ram_credit(ram_credit), .ram_dout(ram_dout), .ram_dout_valid(ram_dout_valid)
    );

    always #10 clk = ~clk;                              // 20 ns period

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};                  // One step per bit
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'(a[ADDR_W-1:24]) ^ 8'h5a;
    endfunction

    function automatic page_cfg_u mk_rom(input mapper_typ_t m, input logic [12:0] base);
        page_cfg_u p;
        p.rom_view.is_ram    = 1'b0;
        p.rom_view.mapper    = m;
        p.rom_view.base_bank = base;
        return p;
    endfunction

    function automatic page_cfg_u mk_ram(input logic ro, input logic [13:0] base);
        page_cfg_u p;
        p.ram_view.is_ram   = 1'b1;
        p.ram_view.ro       = ro;
        p.ram_view.base_seg = base;
        return p;
    endfunction

    // Expected SDRAM address of a CPU access, straight from the page rules
    function automatic logic [ADDR_W-1:0] ref_addr(
        input  page_cfg_u   pc [4],
        input  logic [7:0]  bk [4],
        input  logic [7:0]  sg [4],
        input  logic [15:0] a,
        input  logic        wr,
        output region_t     rgn,
        output logic        drop
    );
        page_cfg_u   pg;
        logic [1:0]  win;
        logic [19:0] off;
        pg  = pc[a[15:14]];
        win = 2'(a[15:13] - 3'd2);                      // 4000h is window 0
        if (pg.rom_view.is_ram) begin
            rgn  = REG_RAM;
            drop = wr && pg.ram_view.ro;
            return ADDR_W'((32'(pg.ram_view.base_seg) + 32'(sg[a[15:14]])) * 32'd16384
                           + 32'(a[13:0]));
        end
        rgn  = REG_ROM;
        drop = wr;                                      // Nothing writes a cartridge
        if (pg.rom_view.mapper == MAP_ASCII8) begin
            off = 20'(32'(bk[win]) * 32'd8192 + 32'(a[12:0]));
        end else begin
            off = 20'(32'(2'(a[15:14] - 2'd1)) * 32'd16384 + 32'(a[13:0]));
        end
        return ADDR_W'(32'(pg.rom_view.base_bank) * 32'd8192 + 32'(off));
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!cpu_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_ready) begin
            run_errs++;
            $display("%s: cpu_ready stayed low for %0d cycles", cur_test, TIMEOUT);
        end
    endtask

    task automatic access(input logic [15:0] a, input logic wr, input logic [7:0] d);
        region_t           rgn;
        logic              drop;
        logic [ADDR_W-1:0] ea;
        wait_ready();
        ea = ref_addr(page_cfg, mdl_bank, mdl_seg, a, wr, rgn, drop);
        if (!drop) begin
            exp_req.push_back({wr, ea, d});
            if (wr) begin
                shadow[ea] = d;
            end else begin
                exp_rd.push_back(shadow.exists(ea) ? shadow[ea] : fill_byte(ea));
            end
        end
        // Bank select window of an ASCII8 page
        if (wr && rgn == REG_ROM && page_cfg[a[15:14]].rom_view.mapper == MAP_ASCII8
                && a[15:13] == 3'b011) begin
            mdl_bank[a[12:11]] = d;
        end
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_wr   <= wr;
        cpu_addr <= a;
        cpu_dout <= d;
        @(posedge clk);
        cpu_req  <= 1'b0;
        cpu_wr   <= 1'b0;
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] d);
        @(posedge clk);
        cpu_io_wr <= 1'b1;
        cpu_addr  <= {8'h00, port};
        cpu_dout  <= d;
        @(posedge clk);
        cpu_io_wr <= 1'b0;
        if (port[7:2] == 6'h3f) begin
            mdl_seg[port[1:0]] = d & SEG_MASK;          // Ports FCh..FFh only
        end
    endtask

    task automatic set_cfg(input page_cfg_u p0, input page_cfg_u p1,
                           input page_cfg_u p2, input page_cfg_u p3);
        @(posedge clk);
        page_cfg[0] <= p0;
        page_cfg[1] <= p1;
        page_cfg[2] <= p2;
        page_cfg[3] <= p3;
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        errs_at_start = run_errs + cmp_errs;
    endtask

    task automatic end_test();
        int n;
        int e;
        n = 0;
        while ((exp_req.size() != 0 || exp_rd.size() != 0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_req.size() != 0 || exp_rd.size() != 0) begin
            run_errs++;
            $display("%s: %0d requests and %0d reads never arrived", cur_test,
                     exp_req.size(), exp_rd.size());
            exp_req.delete();
            exp_rd.delete();
        end
        repeat (4) @(posedge clk);                      // Room for stray requests
        e = run_errs + cmp_errs - errs_at_start;
        if (e == 0) begin
            tests_pass++;
            $display("PASS %s", cur_test);
        end else begin
            tests_fail++;
            $display("FAIL %s with %0d errors", cur_test, e);
        end
    endtask

    // Every request and every read return against the expected queues
    always @(posedge clk) begin
        logic [ADDR_W+8:0] e;
        logic [7:0]        d;
        if (!rst && ram_req) begin
            if (exp_req.size() == 0) begin
                cmp_errs++;
                $display("%s: unexpected ram_req to %h", cur_test, ram_addr);
            end else begin
                e = exp_req.pop_front();
                cmp_checks++;
                if (e[ADDR_W+8:8] != {ram_op, ram_addr}) begin
                    cmp_errs++;
                    $display("FAILED %s: op/addr expected %h actual %h", cur_test,
                             e[ADDR_W+8:8], {ram_op, ram_addr});
                end else if (e[ADDR_W+8] && e[7:0] != ram_din) begin
                    cmp_errs++;
                    $display("FAILED %s: ram_din expected %h actual %h", cur_test,
                             e[7:0], ram_din);
                end
            end
        end
        if (!rst && cpu_din_valid) begin
            if (exp_rd.size() == 0) begin
                cmp_errs++;
                $display("%s: read data returned with no read pending", cur_test);
            end else begin
                d = exp_rd.pop_front();
                cmp_checks++;
                if (d != cpu_din) begin
                    cmp_errs++;
                    $display("FAILED %s: cpu_din expected %h actual %h", cur_test, d, cpu_din);
                end
            end
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_addr  = 16'd0;
        cpu_dout  = 8'd0;
        cpu_io_wr = 1'b0;
        hold      = 1'b0;
        lfsr      = 32'hd24e;
        cur_test  = "reset";
        for (int i = 0; i < 4; i++) begin
            page_cfg[i] = mk_ram(1'b0, 14'h040);
            mdl_bank[i] = 8'(i);                        // Reset banks 0..3
            mdl_seg[i]  = 8'(3 - i);                    // Reset segments 3..0
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_map");
        for (int p = 0; p < 4; p++) begin
            access(16'(p) * 16'h4000 + 16'h0123, 1'b1, 8'(8'h30 + p));
            access(16'(p) * 16'h4000 + 16'h0123, 1'b0, 8'h00);
            access(16'(p) * 16'h4000 + 16'h3ffe, 1'b0, 8'h00);
        end
        set_cfg(mk_rom(MAP_PLAIN, 13'h100), mk_rom(MAP_PLAIN, 13'h100),
                mk_rom(MAP_PLAIN, 13'h100), mk_rom(MAP_PLAIN, 13'h100));
        for (int p = 0; p < 4; p++) begin
            access(16'(p) * 16'h4000 + 16'h0040, 1'b0, 8'h00);
            access(16'(p) * 16'h4000 + 16'h3fff, 1'b0, 8'h00);
        end
        end_test();

        // Bank selects under hold, so a spent credit would stall the reads
        start_test("ascii8_banks");
        set_cfg(mk_ram(1'b0, 14'h040), mk_rom(MAP_ASCII8, 13'h200),
                mk_rom(MAP_ASCII8, 13'h300), mk_ram(1'b1, 14'h080));
        @(posedge clk);
        hold <= 1'b1;
        for (int w = 0; w < 4; w++) begin
            access(16'h6000 + 16'(w) * 16'h0800, 1'b1, 8'(17 + w * 19));
        end
        for (int w = 0; w < `MSX_CREDITS; w++) begin
            access(16'h4000 + 16'(w % 4) * 16'h2000 + 16'h0155, 1'b0, 8'h00);
        end
        @(posedge clk);
        hold <= 1'b0;
        end_test();

        start_test("io_remap");
        set_cfg(mk_ram(1'b0, 14'h040), mk_ram(1'b0, 14'h040),
                mk_ram(1'b0, 14'h040), mk_ram(1'b0, 14'h040));
        for (int p = 0; p < 4; p++) begin
            io_write(8'(8'hfc + p), 8'(8'h17 + p * 8'h59));
        end
        for (int p = 0; p < 4; p++) begin
            access(16'(p) * 16'h4000 + 16'h2a00, 1'b1, 8'(8'hc0 + p));
            access(16'(p) * 16'h4000 + 16'h2a00, 1'b0, 8'h00);
            access(16'(p) * 16'h4000 + 16'h0123, 1'b0, 8'h00);
        end
        end_test();

        start_test("write_protect");
        set_cfg(mk_ram(1'b0, 14'h040), mk_rom(MAP_ASCII8, 13'h200),
                mk_rom(MAP_PLAIN, 13'h300), mk_ram(1'b1, 14'h080));
        for (int p = 0; p < 4; p++) begin
            access(16'(p) * 16'h4000 + 16'h0100, 1'b1, 8'ha5);  // Only page 0 lands
            access(16'(p) * 16'h4000 + 16'h0100, 1'b0, 8'h00);
        end
        end_test();

        start_test("backpressure");
        @(posedge clk);
        hold <= 1'b1;
        for (int i = 0; i < `MSX_CREDITS; i++) begin
            access(16'h0200 + 16'(i), 1'b0, 8'h00);
        end
        @(negedge clk);
        run_checks++;
        if (cpu_ready) begin
            run_errs++;
            $display("%s: cpu_ready still high with all credits spent", cur_test);
        end
        @(posedge clk);
        hold <= 1'b0;
        wait_ready();
        access(16'hc200, 1'b0, 8'h00);
        end_test();

        start_test("random_burst");
        for (int i = 0; i < 200; i++) begin
            if (rnd(3) == 32'd7) begin
                io_write(8'hfc | 8'(rnd(2)), 8'(rnd(8)));
            end else begin
                access(16'(rnd(16)), rnd(2) == 32'd0, 8'(rnd(8)));
            end
        end
        end_test();

        $display("tests passed %0d failed %0d, checks %0d, errors %0d", tests_pass,
                 tests_fail, run_checks + cmp_checks, run_errs + cmp_errs);
        if (tests_fail == 0 && run_errs + cmp_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/msx_slot_pkg.sv
rtl/msx_mem_pkg.sv
rtl/rom_mapper.sv
rtl/ram_mapper.sv
rtl/slot_mem_arbiter.sv
rtl/msx_slots.sv
testbench/sdram_model.sv
testbench/tb_msx_slots.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_msx_slots
FILELIST  := tb.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
